// ==== logic/dma_regs_pkg.sv ====
// DMA register-side definitions
// register map, control and status layouts, and load strobes to the masters
`default_nettype none

package dma_regs_pkg;

  localparam int CTL_ADDR_W = 3;
  localparam int REG_DATA_W = 27;

  typedef enum logic [CTL_ADDR_W-1:0] {
    REG_STATUS        = 3'd0,
    REG_READ_ADDR     = 3'd1,
    REG_WRITE_ADDR    = 3'd2,
    REG_LENGTH        = 3'd3,
    REG_CONTROL       = 3'd6,
    REG_CONTROL_ALIAS = 3'd7
  } dma_reg_addr_e;

  // bit positions of the control fields in the register word
  localparam int CTRL_BYTE_BIT = 0;
  localparam int CTRL_HW_BIT   = 1;
  localparam int CTRL_GO_BIT   = 3;
  localparam int CTRL_I_EN_BIT = 4;
  localparam int CTRL_LEEN_BIT = 7;
  localparam int CTRL_RCON_BIT = 8;
  localparam int CTRL_WCON_BIT = 9;

  typedef struct packed {
    logic wcon;
    logic rcon;
    logic leen;
    logic i_en;
    logic go;
    logic hw;
    logic byte_access;
  } dma_ctrl_t;

  // length-end enabled, everything else off
  localparam dma_ctrl_t CTRL_RESET = '{leen: 1'b1, default: 1'b0};

  // status word, bits 4 down to 0
  typedef struct packed {
    logic len;
    logic rsvd_weop;
    logic rsvd_reop;
    logic busy;
    logic done;
  } dma_status_t;

  typedef struct packed {
    logic                  load_read_addr;
    logic                  load_write_addr;
    logic                  load_length;
    logic                  load_control_go;
    logic [REG_DATA_W-1:0] value;
  } dma_load_t;

  function automatic dma_ctrl_t ctrl_from_word(input logic [REG_DATA_W-1:0] w);
    dma_ctrl_t c;
    c.byte_access = w[CTRL_BYTE_BIT];
    c.hw          = w[CTRL_HW_BIT];
    c.go          = w[CTRL_GO_BIT];
    c.i_en        = w[CTRL_I_EN_BIT];
    c.leen        = w[CTRL_LEEN_BIT];
    c.rcon        = w[CTRL_RCON_BIT];
    c.wcon        = w[CTRL_WCON_BIT];
    return c;
  endfunction

  function automatic logic [REG_DATA_W-1:0] ctrl_to_word(input dma_ctrl_t c);
    logic [REG_DATA_W-1:0] w;
    w                = '0;
    w[CTRL_BYTE_BIT] = c.byte_access;
    w[CTRL_HW_BIT]   = c.hw;
    w[CTRL_GO_BIT]   = c.go;
    w[CTRL_I_EN_BIT] = c.i_en;
    w[CTRL_LEEN_BIT] = c.leen;
    w[CTRL_RCON_BIT] = c.rcon;
    w[CTRL_WCON_BIT] = c.wcon;
    return w;
  endfunction

endpackage

`default_nettype wire

// ==== logic/dma_bus_pkg.sv ====
// DMA bus-side definitions
// master port widths, FIFO sizing, and request and response bundles
`default_nettype none

package dma_bus_pkg;

  localparam int ADDR_W     = 27;
  localparam int DATA_W     = 16;
  localparam int LEN_W      = 26;
  localparam int FIFO_DEPTH = 64;
  localparam int FIFO_AW    = 6;

  typedef struct packed {
    logic              chipselect;
    logic [ADDR_W-1:0] address;
  } dma_rd_req_t;

  typedef struct packed {
    logic              waitrequest;
    logic              readdatavalid;
    logic [DATA_W-1:0] readdata;
  } dma_rd_rsp_t;

  typedef struct packed {
    logic                  chipselect;
    logic [ADDR_W-1:0]     address;
    logic [DATA_W/8-1:0]   byteenable;
    logic [DATA_W-1:0]     writedata;
  } dma_wr_req_t;

  typedef enum logic {
    RD_IDLE,
    RD_ACCESS
  } dma_rd_state_e;

endpackage

`default_nettype wire

// ==== logic/dma_fifo.sv ====
// DMA data FIFO
// 64 words between the read and write masters; full is estimated from reads
// already issued so returned data always has room
`timescale 1ns/1ps
`default_nettype none

module dma_fifo (
  input  logic                           clk,
  input  logic                           reset_n,
  input  logic                           write,
  input  logic [dma_bus_pkg::DATA_W-1:0] wr_data,
  input  logic                           read,
  input  logic                           flush,
  input  logic                           inc_pending,
  output logic [dma_bus_pkg::DATA_W-1:0] rd_data,
  output logic                           not_empty,
  output logic                           full_next
);
  import dma_bus_pkg::*;

  logic [DATA_W-1:0]  mem [FIFO_DEPTH];
  logic [DATA_W-1:0]  ram_q;
  logic [DATA_W-1:0]  bypass_data;
  logic               bypass_valid;
  logic [FIFO_AW-1:0] wr_ptr;
  logic [FIFO_AW-1:0] rd_ptr;
  logic [FIFO_AW-1:0] rd_ptr_next;
  logic [FIFO_AW-1:0] est_wr_ptr;
  logic               empty;
  logic               empty_next;
  logic               full;
  logic               grow;
  logic               shrink;
  logic               collision;

  assign grow   = write & ~read;
  assign shrink = read & ~write;

  // pointers count down
  assign rd_ptr_next = flush ? '0 : (read ? rd_ptr - 1'b1 : rd_ptr);

  assign empty_next = flush | (~grow & empty) | (shrink & (wr_ptr == rd_ptr - 1'b1));
  // est_wr_ptr moves on every issued read, ahead of the data
  assign full_next  = ~flush &
                      ((~shrink & full) | (inc_pending & (est_wr_ptr == rd_ptr_next)));

  assign collision = write && wr_ptr == rd_ptr_next;
  assign not_empty = ~empty;
  assign rd_data   = bypass_valid ? bypass_data : ram_q;

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      wr_ptr       <= '0;
      rd_ptr       <= '0;
      est_wr_ptr   <= '1;
      empty        <= 1'b1;
      full         <= 1'b0;
      bypass_valid <= 1'b0;
    end
    else
    begin
      rd_ptr <= rd_ptr_next;
      empty  <= empty_next;
      full   <= full_next;
      if (flush)
      begin
        wr_ptr     <= '0;
        est_wr_ptr <= '1;
      end
      else
      begin
        if (write)
          wr_ptr <= wr_ptr - 1'b1;
        if (inc_pending)
          est_wr_ptr <= est_wr_ptr - 1'b1;
      end
      if (collision)
        bypass_valid <= 1'b1;
      else if (read)
        bypass_valid <= 1'b0;
    end
  end

  // registered read port returns old data on a same-slot write
  always_ff @(posedge clk)
  begin
    if (write)
      mem[wr_ptr] <= wr_data;
    ram_q <= mem[rd_ptr_next];
  end

  always_ff @(posedge clk)
  begin
    if (collision)
      bypass_data <= wr_data;
  end

  no_read_when_empty: assert property (@(posedge clk) disable iff (!reset_n)
    read |-> !empty)
    else $error("FIFO read while empty");

endmodule

`default_nettype wire

// ==== logic/dma_read_master.sv ====
// DMA read master
// issues reads from the source address while the FIFO has room and the
// length lasts, and steers returned bytes into the FIFO write data
`timescale 1ns/1ps
`default_nettype none

module dma_read_master (
  input  logic                           clk,
  input  logic                           reset_n,
  input  dma_regs_pkg::dma_load_t        load,
  input  dma_regs_pkg::dma_ctrl_t        ctrl,
  output dma_bus_pkg::dma_rd_req_t       rd_req,
  input  dma_bus_pkg::dma_rd_rsp_t       rd_rsp,
  input  logic                           full_next,
  input  logic                           done_write_next,
  output logic                           inc_read,
  output logic [dma_bus_pkg::DATA_W-1:0] fifo_wr_data,
  output logic [dma_bus_pkg::ADDR_W-1:0] read_addr
);
  import dma_bus_pkg::*;

  dma_rd_state_e     state;
  dma_rd_state_e     state_next;
  logic              start;
  logic [LEN_W-1:0]  length;
  logic [LEN_W-1:0]  step;
  logic [ADDR_W-1:0] addr_inc;
  logic              length_zero;
  logic              length_zero_next;
  logic              done_read_next;
  logic              lane_sel;

  // 1 byte or 2 bytes per access
  assign step     = LEN_W'({ctrl.hw, ctrl.byte_access});
  assign addr_inc = ctrl.rcon ? '0 : ADDR_W'({ctrl.hw, ctrl.byte_access});

  assign rd_req   = '{chipselect: state == RD_ACCESS, address: read_addr};
  assign inc_read = rd_req.chipselect & ~rd_rsp.waitrequest;

  assign length_zero_next = inc_read && !length_zero && (length - step) == '0;
  assign done_read_next   = (ctrl.leen && (length_zero_next || length_zero)) ||
                            done_write_next;

  // a go write starts the machine without waiting for the control register
  assign start = ctrl.go | load.load_control_go;

  always_comb
  begin
    state_next = state;
    case (state)
      RD_IDLE:
        if (start && !full_next && !done_read_next)
          state_next = RD_ACCESS;
      RD_ACCESS:
        if (!rd_rsp.waitrequest && (full_next || done_read_next))
          state_next = RD_IDLE;
      default:
        state_next = RD_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      state       <= RD_IDLE;
      read_addr   <= '0;
      length      <= '0;
      length_zero <= 1'b1;
      lane_sel    <= 1'b0;
    end
    else
    begin
      state <= state_next;
      if (load.load_read_addr)
        read_addr <= load.value[ADDR_W-1:0];
      else if (inc_read)
        read_addr <= read_addr + addr_inc;
      if (load.load_length)
        length <= load.value[LEN_W-1:0];
      else if (inc_read && !length_zero)
        length <= length - step;
      if (load.load_length)
        length_zero <= 1'b0;
      else if (length_zero_next)
        length_zero <= 1'b1;
      // lane of the next returned byte, toggling per word in byte mode
      if (load.load_control_go || load.load_length)
        lane_sel <= read_addr[0];
      else if (rd_rsp.readdatavalid)
        lane_sel <= lane_sel ^ addr_inc[0];
    end
  end

  assign fifo_wr_data = {rd_rsp.readdata[DATA_W-1:8],
                         (ctrl.byte_access && lane_sel) ? rd_rsp.readdata[DATA_W-1:8]
                                                        : rd_rsp.readdata[7:0]};

  rd_hold_on_wait: assert property (@(posedge clk) disable iff (!reset_n)
    rd_req.chipselect && rd_rsp.waitrequest |=>
      rd_req.chipselect && $stable(rd_req.address))
    else $error("read request changed under waitrequest");

endmodule

`default_nettype wire

// ==== logic/dma_write_master.sv ====
// DMA write master
// drains the FIFO to the destination address, forms byte enables and lane
// copies, and flags the end of the transfer
`timescale 1ns/1ps
`default_nettype none

module dma_write_master (
  input  logic                           clk,
  input  logic                           reset_n,
  input  dma_regs_pkg::dma_load_t        load,
  input  dma_regs_pkg::dma_ctrl_t        ctrl,
  output dma_bus_pkg::dma_wr_req_t       wr_req,
  input  logic                           waitrequest,
  input  logic                           not_empty,
  input  logic [dma_bus_pkg::DATA_W-1:0] rd_data,
  output logic                           fifo_read,
  output logic [dma_bus_pkg::ADDR_W-1:0] write_addr,
  output logic [dma_bus_pkg::LEN_W-1:0]  write_length,
  output logic                           done_write,
  output logic                           done_write_next,
  output logic                           write_length_zero
);
  import dma_bus_pkg::*;

  logic [LEN_W-1:0]    step;
  logic [ADDR_W-1:0]   addr_inc;
  logic                length_zero_next;
  logic [DATA_W/8-1:0] byteenable;
  logic [DATA_W-1:0]   writedata;

  assign step     = LEN_W'({ctrl.hw, ctrl.byte_access});
  assign addr_inc = ctrl.wcon ? '0 : ADDR_W'({ctrl.hw, ctrl.byte_access});

  // a write is accepted on the first cycle without waitrequest
  assign fifo_read = not_empty & ~waitrequest;

  assign length_zero_next = fifo_read && !write_length_zero && (write_length - step) == '0;
  assign done_write_next  = ctrl.leen && (length_zero_next || write_length_zero);

  // bytes go to the lane picked by address bit 0, on both lanes of the data
  assign byteenable = ctrl.byte_access ? {write_addr[0], ~write_addr[0]} : {ctrl.hw, ctrl.hw};
  assign writedata  = ctrl.byte_access ? {2{rd_data[7:0]}} : rd_data;

  assign wr_req = '{
    chipselect: not_empty,
    address:    write_addr,
    byteenable: byteenable,
    writedata:  writedata
  };

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      write_addr        <= '0;
      write_length      <= '0;
      write_length_zero <= 1'b1;
      done_write        <= 1'b0;
    end
    else
    begin
      done_write <= done_write_next;
      if (load.load_write_addr)
        write_addr <= load.value[ADDR_W-1:0];
      else if (fifo_read)
        write_addr <= write_addr + addr_inc;
      if (load.load_length)
        write_length <= load.value[LEN_W-1:0];
      else if (fifo_read && !write_length_zero)
        write_length <= write_length - step;
      if (load.load_length)
        write_length_zero <= 1'b0;
      else if (length_zero_next)
        write_length_zero <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== logic/dma_ctl_regs.sv ====
// DMA control registers
// decodes register writes into load strobes, holds the control word and the
// done and len status bits, raises the interrupt and flushes the FIFO when
// a transfer completes
`timescale 1ns/1ps
`default_nettype none

module dma_ctl_regs (
  input  logic                                clk,
  input  logic                                reset_n,
  input  logic                                ctl_chipselect,
  input  logic                                ctl_write_n,
  input  dma_regs_pkg::dma_reg_addr_e         ctl_address,
  input  logic [dma_regs_pkg::REG_DATA_W-1:0] ctl_writedata,
  output logic [dma_regs_pkg::REG_DATA_W-1:0] ctl_readdata,
  input  logic [dma_bus_pkg::ADDR_W-1:0]      read_addr,
  input  logic [dma_bus_pkg::ADDR_W-1:0]      write_addr,
  input  logic [dma_bus_pkg::LEN_W-1:0]       write_length,
  input  logic                                done_write,
  input  logic                                write_length_zero,
  output dma_regs_pkg::dma_load_t             load,
  output dma_regs_pkg::dma_ctrl_t             ctrl,
  output logic                                flush,
  output logic                                irq
);
  import dma_regs_pkg::*;

  logic        reg_write;
  logic        ctrl_write;
  logic        status_write;
  logic        done_transaction;
  logic        done_transaction_d;
  logic        done;
  logic        len;
  dma_status_t status;

  assign reg_write    = ctl_chipselect & ~ctl_write_n;
  assign ctrl_write   = reg_write &&
                        (ctl_address == REG_CONTROL || ctl_address == REG_CONTROL_ALIAS);
  assign status_write = reg_write && ctl_address == REG_STATUS;

  // strobes live only in the cycle of the bus write
  assign load = '{
    load_read_addr:  reg_write && ctl_address == REG_READ_ADDR,
    load_write_addr: reg_write && ctl_address == REG_WRITE_ADDR,
    load_length:     reg_write && ctl_address == REG_LENGTH,
    load_control_go: ctrl_write && ctl_writedata[CTRL_GO_BIT],
    value:           ctl_writedata
  };

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
      ctrl <= CTRL_RESET;
    else if (ctrl_write)
      ctrl <= ctrl_from_word(ctl_writedata);
  end

  // one pulse on the rising edge of completion
  assign done_transaction = ctrl.go & done_write;
  assign flush            = done_transaction & ~done_transaction_d;

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      done_transaction_d <= 1'b0;
      done               <= 1'b0;
      len                <= 1'b0;
    end
    else
    begin
      done_transaction_d <= done_transaction;
      if (status_write)
      begin
        done <= 1'b0;
        len  <= 1'b0;
      end
      else if (flush)
      begin
        done <= 1'b1;
        len  <= len | write_length_zero;
      end
    end
  end

  assign status = '{
    len:       len,
    rsvd_weop: 1'b0,
    rsvd_reop: 1'b0,
    busy:      ctrl.go & ~done_write,
    done:      done
  };

  assign irq = ctrl.i_en & done;

  // readback follows the address whatever the strobes do
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
      ctl_readdata <= '0;
    else
      case (ctl_address)
        REG_STATUS:     ctl_readdata <= REG_DATA_W'(status);
        REG_READ_ADDR:  ctl_readdata <= REG_DATA_W'(read_addr);
        REG_WRITE_ADDR: ctl_readdata <= REG_DATA_W'(write_addr);
        REG_LENGTH:     ctl_readdata <= REG_DATA_W'(write_length);
        REG_CONTROL,
        REG_CONTROL_ALIAS:
          ctl_readdata <= ctrl_to_word(ctrl);
        default:        ctl_readdata <= '0;
      endcase
  end

  irq_needs_done: assert property (@(posedge clk) disable iff (!reset_n)
    irq |-> done)
    else $error("irq high while done is low");

endmodule

`default_nettype wire

// ==== logic/dma_top.sv ====
// DMA engine top level
// register port, read master, data FIFO and write master with their links
`timescale 1ns/1ps
`default_nettype none

module dma_top (
  input  logic                                clk,
  input  logic                                reset_n,
  input  logic                                ctl_chipselect,
  input  logic                                ctl_write_n,
  input  dma_regs_pkg::dma_reg_addr_e         ctl_address,
  input  logic [dma_regs_pkg::REG_DATA_W-1:0] ctl_writedata,
  output logic [dma_regs_pkg::REG_DATA_W-1:0] ctl_readdata,
  output logic                                irq,
  output dma_bus_pkg::dma_rd_req_t            rd_req,
  input  dma_bus_pkg::dma_rd_rsp_t            rd_rsp,
  output dma_bus_pkg::dma_wr_req_t            wr_req,
  input  logic                                wr_waitrequest
);
  import dma_regs_pkg::*;
  import dma_bus_pkg::*;

  dma_load_t         load;
  dma_ctrl_t         ctrl;
  logic              flush;
  logic [ADDR_W-1:0] read_addr;
  logic [ADDR_W-1:0] write_addr;
  logic [LEN_W-1:0]  write_length;
  logic              done_write;
  logic              done_write_next;
  logic              write_length_zero;
  logic              inc_read;
  logic [DATA_W-1:0] fifo_wr_data;
  logic              full_next;
  logic              not_empty;
  logic [DATA_W-1:0] fifo_rd_data;
  logic              fifo_read;

  dma_ctl_regs dma_ctl_regs_inst (
    .clk               (clk),
    .reset_n           (reset_n),
    .ctl_chipselect    (ctl_chipselect),
    .ctl_write_n       (ctl_write_n),
    .ctl_address       (ctl_address),
    .ctl_writedata     (ctl_writedata),
    .ctl_readdata      (ctl_readdata),
    .read_addr         (read_addr),
    .write_addr        (write_addr),
    .write_length      (write_length),
    .done_write        (done_write),
    .write_length_zero (write_length_zero),
    .load              (load),
    .ctrl              (ctrl),
    .flush             (flush),
    .irq               (irq)
  );

  dma_read_master dma_read_master_inst (
    .clk             (clk),
    .reset_n         (reset_n),
    .load            (load),
    .ctrl            (ctrl),
    .rd_req          (rd_req),
    .rd_rsp          (rd_rsp),
    .full_next       (full_next),
    .done_write_next (done_write_next),
    .inc_read        (inc_read),
    .fifo_wr_data    (fifo_wr_data),
    .read_addr       (read_addr)
  );

  // returned read data is pushed as it arrives
  dma_fifo dma_fifo_inst (
    .clk         (clk),
    .reset_n     (reset_n),
    .write       (rd_rsp.readdatavalid),
    .wr_data     (fifo_wr_data),
    .read        (fifo_read),
    .flush       (flush),
    .inc_pending (inc_read),
    .rd_data     (fifo_rd_data),
    .not_empty   (not_empty),
    .full_next   (full_next)
  );

  dma_write_master dma_write_master_inst (
    .clk               (clk),
    .reset_n           (reset_n),
    .load              (load),
    .ctrl              (ctrl),
    .wr_req            (wr_req),
    .waitrequest       (wr_waitrequest),
    .not_empty         (not_empty),
    .rd_data           (fifo_rd_data),
    .fifo_read         (fifo_read),
    .write_addr        (write_addr),
    .write_length      (write_length),
    .done_write        (done_write),
    .done_write_next   (done_write_next),
    .write_length_zero (write_length_zero)
  );

endmodule

`default_nettype wire

// ==== verif/dma_tb.sv ====
// DMA engine testbench
// byte addressed memory model on both master ports, register tasks,
// and concurrent checks on every accepted write and register read
`timescale 1ns/1ps
`default_nettype none

module dma_tb;
  import dma_regs_pkg::*;
  import dma_bus_pkg::*;

  localparam int WAIT_LIMIT = 4000;

  logic                  clk;
  logic                  reset_n;
  logic                  ctl_chipselect;
  logic                  ctl_write_n;
  dma_reg_addr_e         ctl_address;
  logic [REG_DATA_W-1:0] ctl_writedata;
  logic [REG_DATA_W-1:0] ctl_readdata;
  logic                  irq;
  dma_rd_req_t           rd_req;
  dma_rd_rsp_t           rd_rsp;
  dma_wr_req_t           wr_req;
  logic                  wr_waitrequest;

  // memory model and bus bookkeeping
  logic [7:0]        mem [0:4095];
  logic              rand_wait;
  logic              rd_acc_q;
  logic [ADDR_W-1:0] rd_acc_addr_q;
  logic              wr_acc_q;
  dma_wr_req_t       wr_q;
  logic              wr_acc;

  // expected transfer state
  logic [ADDR_W-1:0] src_base;
  logic [ADDR_W-1:0] dst_base;
  logic              byte_mode;
  logic              rcon_mode;
  logic              wcon_mode;
  logic              ien_mode;
  int                wr_count;
  int                exp_count;
  logic              cnt_clear;
  logic [ADDR_W-1:0] step_n;
  logic [ADDR_W-1:0] exp_raddr;
  logic [ADDR_W-1:0] exp_waddr;
  logic [DATA_W-1:0] exp_wdata;
  logic [1:0]        exp_be;

  // check strobes raised by the stimulus
  logic                  rd_check;
  logic [REG_DATA_W-1:0] rd_expect;
  logic                  irq_check;
  logic                  irq_expect;
  logic                  cnt_check;
  int                    errors;
  int                    timeouts;

  dma_top dma_top_inst (
    .clk            (clk),
    .reset_n        (reset_n),
    .ctl_chipselect (ctl_chipselect),
    .ctl_write_n    (ctl_write_n),
    .ctl_address    (ctl_address),
    .ctl_writedata  (ctl_writedata),
    .ctl_readdata   (ctl_readdata),
    .irq            (irq),
    .rd_req         (rd_req),
    .rd_rsp         (rd_rsp),
    .wr_req         (wr_req),
    .wr_waitrequest (wr_waitrequest)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  assign wr_acc = wr_req.chipselect && !wr_waitrequest;

  // next expected source and destination per accepted write
  always_comb
  begin
    step_n    = byte_mode ? ADDR_W'(wr_count) : ADDR_W'(wr_count * 2);
    exp_raddr = rcon_mode ? src_base : src_base + step_n;
    exp_waddr = wcon_mode ? dst_base : dst_base + step_n;
    if (byte_mode)
      exp_wdata = {2{mem[exp_raddr[11:0]]}};
    else
      exp_wdata = {mem[{exp_raddr[11:1], 1'b1}], mem[{exp_raddr[11:1], 1'b0}]};
    exp_be = byte_mode ? {exp_waddr[0], ~exp_waddr[0]} : 2'b11;
  end

  // bus state is stable mid-cycle
  initial
  begin
    rd_acc_q      = 1'b0;
    rd_acc_addr_q = '0;
    wr_acc_q      = 1'b0;
    wr_q          = '0;
    forever
    begin
      @(negedge clk);
      rd_acc_q      = rd_req.chipselect && !rd_rsp.waitrequest;
      rd_acc_addr_q = rd_req.address;
      wr_acc_q      = wr_acc;
      wr_q          = wr_req;
    end
  end

  // memory fill, write side of the model and write counter
  initial
  begin
    void'($urandom(17600));
    for (int i = 0; i < 4096; i++)
      mem[i] <= 8'($urandom);
    wr_count <= 0;
    forever
    begin
      @(posedge clk);
      if (cnt_clear)
        wr_count <= 0;
      else if (wr_acc_q)
        wr_count <= wr_count + 1;
      if (wr_acc_q && wr_q.byteenable[0])
        mem[{wr_q.address[11:1], 1'b0}] <= wr_q.writedata[7:0];
      if (wr_acc_q && wr_q.byteenable[1])
        mem[{wr_q.address[11:1], 1'b1}] <= wr_q.writedata[15:8];
    end
  end

  // read data returns two cycles after acceptance; random stalls on both ports
  initial
  begin
    logic              pend;
    logic [ADDR_W-1:0] pend_addr;
    pend           = 1'b0;
    pend_addr      = '0;
    rd_rsp         = '0;
    wr_waitrequest = 1'b0;
    forever
    begin
      @(posedge clk);
      #1;
      rd_rsp.readdatavalid = pend;
      rd_rsp.readdata      = pend ? {mem[{pend_addr[11:1], 1'b1}],
                                     mem[{pend_addr[11:1], 1'b0}]} : '0;
      pend                 = rd_acc_q;
      pend_addr            = rd_acc_addr_q;
      rd_rsp.waitrequest   = rand_wait && ($urandom % 3 == 0);
      wr_waitrequest       = rand_wait && ($urandom % 3 == 0);
    end
  end

  chk_wdata: assert property (@(posedge clk) disable iff (!reset_n)
    wr_acc |-> wr_req.writedata == exp_wdata)
    else
    begin
      errors++;
      $display("ERR wr_req.writedata exp %h got %h", $sampled(exp_wdata),
               $sampled(wr_req.writedata));
    end

  chk_waddr: assert property (@(posedge clk) disable iff (!reset_n)
    wr_acc |-> wr_req.address == exp_waddr)
    else
    begin
      errors++;
      $display("ERR wr_req.address exp %h got %h", $sampled(exp_waddr),
               $sampled(wr_req.address));
    end

  chk_be: assert property (@(posedge clk) disable iff (!reset_n)
    wr_acc |-> wr_req.byteenable == exp_be)
    else
    begin
      errors++;
      $display("ERR wr_req.byteenable exp %h got %h", $sampled(exp_be),
               $sampled(wr_req.byteenable));
    end

  chk_no_extra: assert property (@(posedge clk) disable iff (!reset_n)
    wr_acc |-> wr_count < exp_count)
    else
    begin
      errors++;
      $display("write accepted beyond the programmed length");
    end

  chk_raddr: assert property (@(posedge clk) disable iff (!reset_n)
    rd_req.chipselect && rcon_mode |-> rd_req.address == src_base)
    else
    begin
      errors++;
      $display("ERR rd_req.address exp %h got %h", $sampled(src_base),
               $sampled(rd_req.address));
    end

  chk_readback: assert property (@(posedge clk) disable iff (!reset_n)
    rd_check |-> ctl_readdata == rd_expect)
    else
    begin
      errors++;
      $display("ERR ctl_readdata exp %h got %h", $sampled(rd_expect),
               $sampled(ctl_readdata));
    end

  chk_irq: assert property (@(posedge clk) disable iff (!reset_n)
    irq_check |-> irq == irq_expect)
    else
    begin
      errors++;
      $display("ERR irq exp %h got %h", $sampled(irq_expect), $sampled(irq));
    end

  chk_irq_enable: assert property (@(posedge clk) disable iff (!reset_n)
    irq |-> ien_mode)
    else
    begin
      errors++;
      $display("irq raised with the interrupt disabled");
    end

  chk_count: assert property (@(posedge clk) disable iff (!reset_n)
    cnt_check |-> wr_count == exp_count)
    else
    begin
      errors++;
      $display("ERR wr_count exp %h got %h", $sampled(exp_count), $sampled(wr_count));
    end

  task automatic write_reg(input dma_reg_addr_e addr, input logic [REG_DATA_W-1:0] data);
    @(posedge clk);
    #1;
    ctl_chipselect = 1'b1;
    ctl_write_n    = 1'b0;
    ctl_address    = addr;
    ctl_writedata  = data;
    @(posedge clk);
    #1;
    ctl_chipselect = 1'b0;
    ctl_write_n    = 1'b1;
  endtask

  task automatic read_reg(input dma_reg_addr_e addr, input logic [REG_DATA_W-1:0] expect_val);
    @(posedge clk);
    #1;
    ctl_address = addr;
    @(posedge clk);
    #1;
    rd_expect = expect_val;
    rd_check  = 1'b1;
    @(posedge clk);
    #1;
    rd_check = 1'b0;
  endtask

  task automatic expect_irq(input logic level);
    @(posedge clk);
    #1;
    irq_expect = level;
    irq_check  = 1'b1;
    @(posedge clk);
    #1;
    irq_check = 1'b0;
  endtask

  // polls the done bit through readback
  task automatic wait_done();
    int n;
    n           = 0;
    ctl_address = REG_STATUS;
    while (n < WAIT_LIMIT && !ctl_readdata[0])
    begin
      @(posedge clk);
      #1;
      n++;
    end
    if (n == WAIT_LIMIT)
    begin
      timeouts++;
      $display("timeout waiting for the transfer to complete");
    end
  endtask

  task automatic run_copy(input logic [ADDR_W-1:0] src, input logic [ADDR_W-1:0] dst,
                          input int len, input logic [REG_DATA_W-1:0] ctrl_word);
    write_reg(REG_CONTROL, 27'h80);
    src_base  = src;
    dst_base  = dst;
    byte_mode = ctrl_word[0];
    ien_mode  = ctrl_word[4];
    rcon_mode = ctrl_word[8];
    wcon_mode = ctrl_word[9];
    exp_count = byte_mode ? len : len / 2;
    @(posedge clk);
    #1;
    cnt_clear = 1'b1;
    @(posedge clk);
    #1;
    cnt_clear = 1'b0;
    write_reg(REG_READ_ADDR, REG_DATA_W'(src));
    write_reg(REG_WRITE_ADDR, REG_DATA_W'(dst));
    write_reg(REG_LENGTH, REG_DATA_W'(len));
    write_reg(REG_CONTROL, ctrl_word | 27'h88);
    wait_done();
    @(posedge clk);
    #1;
    cnt_check = 1'b1;
    @(posedge clk);
    #1;
    cnt_check = 1'b0;
    // done and len set, busy clear
    read_reg(REG_STATUS, 27'h11);
    expect_irq(ien_mode);
    write_reg(REG_STATUS, '0);
    read_reg(REG_STATUS, '0);
    expect_irq(1'b0);
  endtask

  initial
  begin
    #200000;
    $display("watchdog expired before the test finished");
    $display("TEST FAILED");
    $finish;
  end

  initial
  begin
    reset_n        = 1'b0;
    ctl_chipselect = 1'b0;
    ctl_write_n    = 1'b1;
    ctl_address    = REG_STATUS;
    ctl_writedata  = '0;
    rand_wait      = 1'b0;
    src_base       = '0;
    dst_base       = '0;
    byte_mode      = 1'b0;
    rcon_mode      = 1'b0;
    wcon_mode      = 1'b0;
    ien_mode       = 1'b0;
    exp_count      = 0;
    cnt_clear      = 1'b0;
    rd_check       = 1'b0;
    rd_expect      = '0;
    irq_check      = 1'b0;
    irq_expect     = 1'b0;
    cnt_check      = 1'b0;
    errors         = 0;
    timeouts       = 0;
    repeat (2) @(posedge clk);
    #1;
    reset_n = 1'b1;

    // register readback
    read_reg(REG_STATUS, '0);
    write_reg(REG_READ_ADDR, 27'h4abcde1);
    read_reg(REG_READ_ADDR, 27'h4abcde1);
    write_reg(REG_WRITE_ADDR, 27'h2345678);
    read_reg(REG_WRITE_ADDR, 27'h2345678);
    write_reg(REG_LENGTH, 27'h1234);
    read_reg(REG_LENGTH, 27'h1234);
    write_reg(REG_CONTROL, 27'h392);
    read_reg(REG_CONTROL, 27'h392);
    read_reg(REG_CONTROL_ALIAS, 27'h392);

    rand_wait = 1'b1;
    // halfword copy with interrupt enabled, long enough to fill the FIFO
    run_copy(27'h100, 27'h800, 160, 27'h012);
    // byte copy from an odd source
    run_copy(27'h201, 27'h900, 21, 27'h001);
    // constant source and destination
    run_copy(27'h300, 27'ha00, 16, 27'h302);

    $display("errors: %0d assertion, %0d timeout", errors, timeouts);
    if (errors == 0 && timeouts == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== compile.f ====
logic/dma_regs_pkg.sv
logic/dma_bus_pkg.sv
logic/dma_fifo.sv
logic/dma_read_master.sv
logic/dma_write_master.sv
logic/dma_ctl_regs.sv
logic/dma_top.sv
verif/dma_tb.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = dma_tb
FILELIST  = compile.f
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check the log for the pass message"
	@echo "  clean  remove build output and the log"
	@echo "  help   list the targets"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "TEST OK" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
